// ==== verilog/fix_config.svh ====
`ifndef FIX_CONFIG_SVH
`define FIX_CONFIG_SVH

// Binary length and decimal result widths
`define FIX_VALUE_WIDTH		16
`define FIX_DIGITS		5

// Tag lengths, tag number plus '='
`define FIX_L_T_MSG_SEQ_NUM	3	// 34=
`define FIX_L_T_MSG_TYPE	3	// 35=
`define FIX_L_T_SENDER_COMP_ID	3	// 49=
`define FIX_L_T_SENDING_TIME	3	// 52=
`define FIX_L_T_TARGET_COMP_ID	3	// 56=
`define FIX_L_T_ENCRYPT_METHOD	3	// 98=
`define FIX_L_T_HEART_BT_INT	4	// 108=

// Fixed value lengths
`define FIX_L_V_MSG_TYPE	1
`define FIX_L_V_SENDER_COMP_ID	8
`define FIX_L_V_SENDING_TIME	17	// YYYYMMDD-HH:MM:SS
`define FIX_L_V_ENCRYPT_METHOD	1
`define FIX_L_V_HEART_BT_INT	4

// SOH separators counted for the logon body
`define FIX_LOGON_SEPARATORS	7

// Shared by logon, logout and heartbeat, 41 in total
`define FIX_COMMON_FIXED	(`FIX_L_T_MSG_SEQ_NUM + \
				 `FIX_L_T_MSG_TYPE + `FIX_L_V_MSG_TYPE + \
				 `FIX_L_T_SENDER_COMP_ID + `FIX_L_V_SENDER_COMP_ID + \
				 `FIX_L_T_SENDING_TIME + `FIX_L_V_SENDING_TIME + \
				 `FIX_L_T_TARGET_COMP_ID)

// Logon only, 19 in total
`define FIX_LOGON_EXTRA		(`FIX_L_T_ENCRYPT_METHOD + `FIX_L_V_ENCRYPT_METHOD + \
				 `FIX_L_T_HEART_BT_INT + `FIX_L_V_HEART_BT_INT + \
				 `FIX_LOGON_SEPARATORS)

// Cycles from accepted start to valid
`define FIX_LEN_LATENCY		20

`endif

// ==== verilog/fix_pkg.sv ====
`include "fix_config.svh"

package fix_pkg;

	// Message type codes, anything else is unsupported
	typedef enum logic [3:0] {
		LOGON		= 4'h1,
		LOGOUT		= 4'h2,
		HEARTBEAT	= 4'h3
	} fix_msg_e;

	// Length controller states
	typedef enum logic [1:0] {
		IDLE	= 2'd0,
		CALC	= 2'd1,	// Sum selected, waiting to register
		CONV	= 2'd2,	// Converter running
		DONE	= 2'd3
	} fix_state_e;

	// Request from the sender
	typedef struct packed {
		fix_msg_e	msg_type;
		logic [3:0]	seq_num_len;	// MsgSeqNum digits
		logic [5:0]	target_len;	// TargetCompID text length
	} fix_req_t;

	// BodyLength as ASCII, first character in byte 0
	typedef struct packed {
		logic [8*`FIX_DIGITS-1:0]	ascii;
		logic [2:0]			digits;
	} fix_len_result_t;

endpackage

// ==== verilog/fix_body_length.sv ====
`timescale 1ns/1ps

`include "fix_config.svh"

module fix_body_length (
	input  fix_pkg::fix_req_t		req_i,
	output logic [`FIX_VALUE_WIDTH-1:0]	length_o,
	output logic				unsupported_o
);

	localparam int W = `FIX_VALUE_WIDTH;

	// Fixed parts of the body
	localparam logic [W-1:0] COMMON_LEN = W'(`FIX_COMMON_FIXED);
	localparam logic [W-1:0] LOGON_LEN = W'(`FIX_LOGON_EXTRA);

	logic [W-1:0] seq_len;
	logic [W-1:0] target_len;
	logic [W-1:0] var_len;

	assign seq_len = W'(req_i.seq_num_len);
	assign target_len = W'(req_i.target_len);

	// Both variable fields appear in every supported type
	assign var_len = seq_len + target_len;

	always_comb begin
		length_o = '0;
		unsupported_o = 1'b0;

		case (req_i.msg_type)
			fix_pkg::LOGON: begin
				length_o = COMMON_LEN + LOGON_LEN + var_len;
			end
			fix_pkg::LOGOUT,
			fix_pkg::HEARTBEAT: begin
				length_o = COMMON_LEN + var_len;
			end
			default: begin
				unsupported_o = 1'b1;	// No conversion follows
			end
		endcase
	end

endmodule

// ==== verilog/fix_bin_to_ascii.sv ====
`timescale 1ns/1ps

`include "fix_config.svh"

module fix_bin_to_ascii #(
	parameter int DIGITS = `FIX_DIGITS
) (
	input  logic				clk,
	input  logic				arst_n_i,
	input  logic				start_i,
	input  logic [`FIX_VALUE_WIDTH-1:0]	value_i,
	output logic				done_o,
	output fix_pkg::fix_len_result_t	result_o
);

	localparam int W = `FIX_VALUE_WIDTH;
	localparam int STEP_W = $clog2(W);

	logic			active_q;	// Shift steps in progress
	logic			pack_q;		// BCD complete, pack next
	logic			done_q;
	logic [STEP_W-1:0]	step_q;
	logic [W-1:0]		bin_q;
	logic [4*DIGITS-1:0]	bcd_q;
	logic [4*DIGITS-1:0]	bcd_adj;
	fix_pkg::fix_len_result_t	packed_res;
	fix_pkg::fix_len_result_t	result_q;

	// Add 3 to every digit of 5 or more before the shift
	always_comb begin
		bcd_adj = bcd_q;
		for (int i = 0; i < DIGITS; i++) begin
			if (bcd_q[4*i +: 4] > 4'd4) begin
				bcd_adj[4*i +: 4] = bcd_q[4*i +: 4] + 4'd3;
			end
		end
	end

	// Significant digit count, then left-aligned ASCII
	always_comb begin
		int n;
		n = 1;
		for (int i = 1; i < DIGITS; i++) begin
			if (bcd_q[4*i +: 4] != 4'd0) begin
				n = i + 1;
			end
		end

		packed_res = '0;
		packed_res.digits = 3'(n);
		for (int k = 0; k < DIGITS; k++) begin
			if (k < n) begin
				packed_res.ascii[8*k +: 8] = {4'h3, bcd_q[4*(n-1-k) +: 4]};
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			active_q <= 1'b0;
			pack_q <= 1'b0;
			done_q <= 1'b0;
			step_q <= '0;
		end else begin
			pack_q <= 1'b0;
			done_q <= pack_q;
			if (start_i) begin
				active_q <= 1'b1;
				step_q <= '0;
			end else if (active_q) begin
				step_q <= step_q + 1'b1;
				if (step_q == STEP_W'(W - 1)) begin	// Last of W steps
					active_q <= 1'b0;
					pack_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			bin_q <= value_i;
			bcd_q <= '0;
		end else if (active_q) begin
			{bcd_q, bin_q} <= {bcd_adj, bin_q} << 1;
		end

		if (pack_q) begin
			result_q <= packed_res;	// Held until the next conversion
		end
	end

	assign done_o = done_q;
	assign result_o = result_q;

endmodule

// ==== verilog/fix_length_ctrl.sv ====
`timescale 1ns/1ps

`include "fix_config.svh"

module fix_length_ctrl (
	input  logic				clk,
	input  logic				arst_n_i,
	input  logic				start_i,
	input  fix_pkg::fix_req_t		req_i,
	input  logic [`FIX_VALUE_WIDTH-1:0]	length_i,
	input  logic				unsupported_i,
	input  logic				conv_done_i,
	input  fix_pkg::fix_len_result_t	conv_result_i,
	output fix_pkg::fix_req_t		req_o,
	output logic				conv_start_o,
	output logic [`FIX_VALUE_WIDTH-1:0]	conv_value_o,
	output logic				valid_o,
	output logic				error_o,
	output logic				busy_o,
	output fix_pkg::fix_len_result_t	result_o
);

	fix_pkg::fix_state_e		state_q;
	fix_pkg::fix_req_t		req_q;
	logic [`FIX_VALUE_WIDTH-1:0]	conv_value_q;
	logic				conv_start_q;
	logic				valid_q;
	logic				error_q;
	fix_pkg::fix_len_result_t	result_q;
	logic				accept;

	// Starts are dropped while busy, error cycle included
	assign accept = (state_q == fix_pkg::IDLE) && start_i && !error_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= fix_pkg::IDLE;
			conv_start_q <= 1'b0;
			valid_q <= 1'b0;
			error_q <= 1'b0;
			result_q <= '0;
		end else begin
			conv_start_q <= 1'b0;
			valid_q <= 1'b0;
			error_q <= 1'b0;

			case (state_q)
				fix_pkg::IDLE: begin
					if (accept) begin
						state_q <= fix_pkg::CALC;
					end
				end
				fix_pkg::CALC: begin
					if (unsupported_i) begin
						error_q <= 1'b1;
						state_q <= fix_pkg::IDLE;
					end else begin
						conv_start_q <= 1'b1;
						state_q <= fix_pkg::CONV;
					end
				end
				fix_pkg::CONV: begin
					if (conv_done_i) begin
						result_q <= conv_result_i;
						valid_q <= 1'b1;
						state_q <= fix_pkg::DONE;
					end
				end
				default: begin
					state_q <= fix_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_i;
		end
		if (state_q == fix_pkg::CALC) begin
			conv_value_q <= length_i;
		end
	end

	assign req_o = req_q;
	assign conv_start_o = conv_start_q;
	assign conv_value_o = conv_value_q;
	assign valid_o = valid_q;
	assign error_o = error_q;
	assign busy_o = (state_q != fix_pkg::IDLE) || error_q;
	assign result_o = result_q;

endmodule

// ==== verilog/fix_header_top.sv ====
`timescale 1ns/1ps

`include "fix_config.svh"

module fix_header_top (
	input  logic				clk,
	input  logic				arst_n_i,
	input  logic				start_i,
	input  fix_pkg::fix_req_t		req_i,
	output logic				valid_o,
	output logic				error_o,
	output logic				busy_o,
	output fix_pkg::fix_len_result_t	result_o
);

	fix_pkg::fix_req_t		req;		// Latched request
	logic [`FIX_VALUE_WIDTH-1:0]	length;
	logic				unsupported;
	logic				conv_start;
	logic [`FIX_VALUE_WIDTH-1:0]	conv_value;
	logic				conv_done;
	fix_pkg::fix_len_result_t	conv_result;

	fix_length_ctrl fix_length_ctrl_inst (
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.start_i	(start_i),
		.req_i		(req_i),
		.length_i	(length),
		.unsupported_i	(unsupported),
		.conv_done_i	(conv_done),
		.conv_result_i	(conv_result),
		.req_o		(req),
		.conv_start_o	(conv_start),
		.conv_value_o	(conv_value),
		.valid_o	(valid_o),
		.error_o	(error_o),
		.busy_o		(busy_o),
		.result_o	(result_o)
	);

	fix_body_length fix_body_length_inst (
		.req_i		(req),
		.length_o	(length),
		.unsupported_o	(unsupported)
	);

	fix_bin_to_ascii #(
		.DIGITS		(`FIX_DIGITS)
	) fix_bin_to_ascii_inst (
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.start_i	(conv_start),
		.value_i	(conv_value),
		.done_o		(conv_done),
		.result_o	(conv_result)
	);

endmodule

// ==== verification/fix_header_sva.sv ====
`timescale 1ns/1ps

`include "fix_config.svh"

module fix_header_sva (
	input logic				clk,
	input logic				arst_n_i,
	input logic				start_i,
	input fix_pkg::fix_req_t		req_i,
	input logic				valid_i,
	input logic				error_i,
	input logic				busy_i,
	input fix_pkg::fix_len_result_t		result_i,
	input fix_pkg::fix_state_e		state_i
);

	localparam int DELAY = `FIX_LEN_LATENCY + 1;	// Start sample to valid sample

	int	fail_count = 0;	// Failed assertions so far
	logic	accepted;
	logic	supported;

	assign accepted = start_i && !busy_i;
	assign supported = (req_i.msg_type == fix_pkg::LOGON) ||
		(req_i.msg_type == fix_pkg::LOGOUT) || (req_i.msg_type == fix_pkg::HEARTBEAT);

	// Body length as decimal ASCII, most significant digit in byte 0
	function automatic fix_pkg::fix_len_result_t expected_result(input fix_pkg::fix_req_t r);
		int len;
		int v;
		int n;
		fix_pkg::fix_len_result_t res;
		len = `FIX_COMMON_FIXED + int'(r.seq_num_len) + int'(r.target_len);
		if (r.msg_type == fix_pkg::LOGON) begin
			len = len + `FIX_LOGON_EXTRA;
		end
		v = len;
		n = 0;
		do begin
			v = v / 10;
			n++;
		end while (v > 0);
		res = '0;
		res.digits = 3'(n);
		v = len;
		for (int k = n - 1; k >= 0; k--) begin
			res.ascii[8*k +: 8] = 8'h30 + 8'(v % 10);	// Least significant digit last
			v = v / 10;
		end
		return res;
	endfunction

	reset_cleared: assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(arst_n_i) |-> !valid_i && !error_i && !busy_i && result_i == '0 &&
			state_i == fix_pkg::IDLE)
		else begin
			fail_count++;
			$error("outputs or state not cleared after reset");
		end

	valid_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i == $past(accepted && supported, DELAY))
		else begin
			fail_count++;
			$error("valid_o not exactly %0d cycles after an accepted start", `FIX_LEN_LATENCY);
		end

	valid_value: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i |-> result_i == expected_result($past(req_i, DELAY)))
		else begin
			fail_count++;
			$error("result_o 0x%0h does not match the body length", result_i);
		end

	error_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
		error_i == $past(accepted && !supported, 2))
		else begin
			fail_count++;
			$error("error_o not one cycle after an unsupported start");
		end

	busy_span: assert property (@(posedge clk) disable iff (!arst_n_i)
		(accepted || (busy_i && !valid_i && !error_i)) |=> busy_i)
		else begin
			fail_count++;
			$error("busy_o fell before valid_o or error_o");
		end

	busy_release: assert property (@(posedge clk) disable iff (!arst_n_i)
		(valid_i || error_i) |-> busy_i ##1 !busy_i)
		else begin
			fail_count++;
			$error("busy_o not released right after valid_o or error_o");
		end

	result_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		!valid_i |-> $stable(result_i))
		else begin
			fail_count++;
			$error("result_o changed without valid_o");
		end

endmodule

// ==== verification/fix_header_tb.sv ====
`timescale 1ns/1ps

`include "fix_config.svh"

module fix_header_tb;

	localparam int TIMEOUT = 4 * `FIX_LEN_LATENCY;

	logic				clk;
	logic				arst_n_i;
	logic				start_i;
	fix_pkg::fix_req_t		req_i;
	logic				valid_o;
	logic				error_o;
	logic				busy_o;
	fix_pkg::fix_len_result_t	result_o;
	integer				seed;
	int				test_cnt;
	int				err_cnt;

	fix_header_top fix_header_top_inst (
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.start_i	(start_i),
		.req_i		(req_i),
		.valid_o	(valid_o),
		.error_o	(error_o),
		.busy_o		(busy_o),
		.result_o	(result_o)
	);

	bind fix_header_top fix_header_sva fix_header_sva_inst (
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.start_i	(start_i),
		.req_i		(req_i),
		.valid_i	(valid_o),
		.error_i	(error_o),
		.busy_i		(busy_o),
		.result_i	(result_o),
		.state_i	(fix_length_ctrl_inst.state_q)
	);

	always #10 clk = ~clk;

	function automatic fix_pkg::fix_len_result_t expected_result(input fix_pkg::fix_req_t r);
		int len;
		string s;
		fix_pkg::fix_len_result_t res;
		len = `FIX_COMMON_FIXED + int'(r.seq_num_len) + int'(r.target_len);
		if (r.msg_type == fix_pkg::LOGON) begin
			len = len + `FIX_LOGON_EXTRA;
		end
		s = $sformatf("%0d", len);
		res = '0;
		res.digits = 3'(s.len());
		for (int k = 0; k < s.len(); k++) begin
			res.ascii[8*k +: 8] = s[k];
		end
		return res;
	endfunction

	task automatic check_value(input string sig, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got 0x%0h expected 0x%0h", sig, got, expected);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_cnt++;
		$display("%s: %s", name, (err_cnt == errs_before) ? "ok" : "failed");
	endtask

	// One request, optionally with a second start pulsed while busy
	task automatic run_request(input logic [3:0] code, input logic [3:0] seq,
			input logic [5:0] tgt, input bit interfere, input string name);
		fix_pkg::fix_req_t req;
		fix_pkg::fix_req_t other;
		fix_pkg::fix_len_result_t exp_res;
		bit supported;
		int cycles;
		int n_valid;
		int n_error;
		int errs_before;
		req.msg_type = fix_pkg::fix_msg_e'(code);
		req.seq_num_len = seq;
		req.target_len = tgt;
		other = req;
		other.seq_num_len = ~seq;
		other.target_len = ~tgt;
		supported = (code >= 4'h1) && (code <= 4'h3);
		exp_res = expected_result(req);
		errs_before = err_cnt;
		cycles = 0;
		n_valid = 0;
		n_error = 0;
		@(posedge clk);
		start_i <= 1'b1;
		req_i <= req;
		do begin
			@(posedge clk);
			if (interfere && cycles == 4) begin
				start_i <= 1'b1;	// Must be dropped
				req_i <= other;
			end else begin
				start_i <= 1'b0;
			end
			@(negedge clk);
			cycles++;
			if (valid_o) begin
				n_valid++;
				check_value({name, " result_o"}, 64'(result_o), 64'(exp_res));
			end
			if (error_o) begin
				n_error++;
			end
		end while (busy_o && cycles < TIMEOUT);
		if (busy_o) begin
			$display("%s: timeout, busy_o still high after %0d cycles", name, cycles);
			err_cnt++;
		end
		if (supported && (n_valid != 1 || n_error != 0)) begin
			$display("%s: expected one valid_o pulse, saw %0d valid_o and %0d error_o",
				name, n_valid, n_error);
			err_cnt++;
		end
		if (!supported && (n_valid != 0 || n_error != 1)) begin
			$display("%s: expected one error_o pulse, saw %0d valid_o and %0d error_o",
				name, n_valid, n_error);
			err_cnt++;
		end
		finish_test(name, errs_before);
	endtask

	initial begin
		logic [3:0] code;
		logic [3:0] seq;
		logic [5:0] tgt;
		int errs;
		int sva_fails;

		clk = 1'b0;
		arst_n_i = 1'b0;
		start_i = 1'b0;
		req_i = '0;
		seed = 32'h987d6953;
		test_cnt = 0;
		err_cnt = 0;

		repeat (10) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		errs = err_cnt;
		check_value("valid_o", 64'(valid_o), 64'h0);
		check_value("error_o", 64'(error_o), 64'h0);
		check_value("busy_o", 64'(busy_o), 64'h0);
		check_value("result_o", 64'(result_o), 64'h0);
		finish_test("reset", errs);

		run_request(4'h1, 4'd3, 6'd6, 1'b0, "logon fixed");
		run_request(4'h2, 4'd2, 6'd10, 1'b0, "logout fixed");
		run_request(4'h3, 4'd5, 6'd12, 1'b0, "heartbeat fixed");
		for (int i = 0; i < 8; i++) begin
			code = 4'(1 + $unsigned($random(seed)) % 3);
			seq = 4'($random(seed));
			tgt = 6'($random(seed));
			run_request(code, seq, tgt, 1'b0, $sformatf("random %0d", i));
		end

		run_request(4'h0, 4'd3, 6'd6, 1'b0, "unsupported 0x0");
		run_request(4'h4, 4'd3, 6'd6, 1'b0, "unsupported 0x4");
		run_request(4'hF, 4'd9, 6'd20, 1'b0, "unsupported 0xf");
		run_request(4'h3, 4'd4, 6'd7, 1'b1, "start while busy");

		// Digit count and alignment across the length range
		run_request(4'h2, 4'd0, 6'd0, 1'b0, "logout minimum");
		run_request(4'h2, 4'd9, 6'd49, 1'b0, "two digit top");
		run_request(4'h3, 4'd9, 6'd50, 1'b0, "three digit bottom");
		run_request(4'h1, 4'd15, 6'd63, 1'b0, "logon maximum");

		repeat (2) @(posedge clk);
		sva_fails = fix_header_top_inst.fix_header_sva_inst.fail_count;
		$display("%0d tests, %0d testbench errors, %0d assertion failures",
			test_cnt, err_cnt, sva_fails);
		if (err_cnt == 0 && sva_fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/fix_pkg.sv
verilog/fix_body_length.sv
verilog/fix_bin_to_ascii.sv
verilog/fix_length_ctrl.sv
verilog/fix_header_top.sv
verification/fix_header_sva.sv
verification/fix_header_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module fix_header_tb -o fix_header_sim

# Failed assertions must not stop the run before the summary
./obj_dir/fix_header_sim +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -x "PASS: all tests" > /dev/null

echo "Simulation passed"
